//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := pipeline_tb
FILELIST  := src.f
PASS_MSG  := Simulation completed successfully

BIN  := obj_dir/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS) common/ooo_defs.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; status=$$?; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)" && [ $$status -eq 0 ]

clean:
	rm -rf obj_dir

//--- common/cdb_if.sv
`timescale 1ns/1ns
`default_nettype none

interface cdb_if;
	logic              req;
	logic              grant;
	logic              valid;     // On a unit bus: result taken this cycle
	ooo_pkg::pr_idx_t  tag;
	ooo_pkg::word_t    value;
	ooo_pkg::rob_idx_t rob_slot;

	modport unit (
		output req, output valid, output tag, output value, output rob_slot,
		input  grant
	);

	modport arbiter (
		input  req, input valid, input tag, input value, input rob_slot,
		output grant
	);

	modport listener (
		input valid, input tag, input value, input rob_slot
	);
endinterface

`default_nettype wire

//--- common/ooo_defs.svh
`ifndef OOO_DEFS_SVH
`define OOO_DEFS_SVH

`define XLEN        64
`define NUM_AR      32
`define NUM_PR      64
`define ROB_DEPTH   16
`define MUL_STAGES  4
`define IMM_W       8

// Index widths
`define AR_W        $clog2(`NUM_AR)
`define PR_W        $clog2(`NUM_PR)
`define ROB_W       $clog2(`ROB_DEPTH)

// Free list holds every register that is unmapped at reset
`define FL_DEPTH    (`NUM_PR - `NUM_AR)
`define FL_W        $clog2(`FL_DEPTH)

`endif

//--- common/ooo_pkg.sv
`default_nettype none
`include "ooo_defs.svh"

package ooo_pkg;

	typedef logic [`XLEN-1:0]  word_t;
	typedef logic [`AR_W-1:0]  ar_idx_t;
	typedef logic [`PR_W-1:0]  pr_idx_t;
	typedef logic [`ROB_W-1:0] rob_idx_t;
	typedef logic [`IMM_W-1:0] imm_t;

	typedef enum logic [2:0] {
		func_add = 3'd0,
		func_sub = 3'd1,
		func_and = 3'd2,
		func_xor = 3'd3,
		func_mul = 3'd4
	} alu_func_e;

	// What rename hands to an execution unit
	typedef struct packed {
		alu_func_e func;
		word_t     a;
		word_t     b;
		pr_idx_t   tag;    // Destination physical register
		rob_idx_t  slot;
	} issue_t;

	typedef enum logic {
		st_idle,
		st_hold
	} cdb_state_e;

endpackage

`default_nettype wire

//--- exec/alu_mul.sv
`timescale 1ns/1ns
`default_nettype none
`include "ooo_defs.svh"

module alu_mul (
	input  wire                   clock,
	input  wire                   arst_n,
	input  wire                   issue,
	input  wire ooo_pkg::issue_t  issue_data,
	cdb_if.unit                   bus
);

	localparam int STAGES = `MUL_STAGES;
	localparam int CHUNK  = `XLEN / `MUL_STAGES;   // Bits of b consumed per stage

	logic [STAGES-1:0]  vld_q;
	ooo_pkg::pr_idx_t   tag_q [STAGES];
	ooo_pkg::rob_idx_t  slot_q [STAGES];
	ooo_pkg::word_t     acc_q [STAGES];
	ooo_pkg::word_t     opa_q [STAGES-1];
	ooo_pkg::word_t     opb_q [STAGES-1];

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			vld_q <= '0;
		else
			vld_q <= {vld_q[STAGES-2:0], issue};
	end

	// Each stage adds one shifted partial product, low XLEN bits only
	always_ff @(posedge clock) begin
		tag_q[0]  <= issue_data.tag;
		slot_q[0] <= issue_data.slot;
		opa_q[0]  <= issue_data.a;
		opb_q[0]  <= issue_data.b;
		acc_q[0]  <= issue_data.a * ooo_pkg::word_t'(issue_data.b[CHUNK-1:0]);
		for (int i = 1; i < STAGES; i++) begin
			tag_q[i]  <= tag_q[i-1];
			slot_q[i] <= slot_q[i-1];
			acc_q[i]  <= acc_q[i-1] +
				((opa_q[i-1] * ooo_pkg::word_t'(opb_q[i-1][i*CHUNK +: CHUNK])) << (i*CHUNK));
		end
		for (int i = 1; i < STAGES-1; i++) begin
			opa_q[i] <= opa_q[i-1];
			opb_q[i] <= opb_q[i-1];
		end
	end

	assign bus.req      = vld_q[STAGES-1];
	assign bus.valid    = bus.req && bus.grant;
	assign bus.tag      = tag_q[STAGES-1];
	assign bus.value    = acc_q[STAGES-1];
	assign bus.rob_slot = slot_q[STAGES-1];

	// No hold stage here, the arbiter must always take the result
	a_mul_granted: assert property (@(posedge clock) disable iff (!arst_n)
		bus.req |-> bus.grant)
		else $error("alu_mul: request not granted");

endmodule

`default_nettype wire

//--- exec/alu_sim.sv
`timescale 1ns/1ns
`default_nettype none

module alu_sim (
	input  wire                   clock,
	input  wire                   arst_n,
	input  wire                   issue,
	input  wire ooo_pkg::issue_t  issue_data,
	output logic                  busy,
	cdb_if.unit                   bus
);

	ooo_pkg::cdb_state_e state_q;
	ooo_pkg::word_t      result;
	ooo_pkg::word_t      result_q;
	ooo_pkg::pr_idx_t    tag_q;
	ooo_pkg::rob_idx_t   slot_q;

	always_comb begin
		case (issue_data.func)
			ooo_pkg::func_add: result = issue_data.a + issue_data.b;
			ooo_pkg::func_sub: result = issue_data.a - issue_data.b;
			ooo_pkg::func_and: result = issue_data.a & issue_data.b;
			ooo_pkg::func_xor: result = issue_data.a ^ issue_data.b;
			default:           result = '0;    // Multiplies go elsewhere
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n)
			state_q <= ooo_pkg::st_idle;
		else if (issue)
			state_q <= ooo_pkg::st_hold;
		else if (bus.grant)
			state_q <= ooo_pkg::st_idle;
	end

	always_ff @(posedge clock) begin
		if (issue) begin
			result_q <= result;
			tag_q    <= issue_data.tag;
			slot_q   <= issue_data.slot;
		end
	end

	assign bus.req      = (state_q == ooo_pkg::st_hold);
	assign bus.valid    = bus.req && bus.grant;
	assign bus.tag      = tag_q;
	assign bus.value    = result_q;
	assign bus.rob_slot = slot_q;

	// A new issue must not land on a result still waiting for the bus
	assign busy = issue || (bus.req && !bus.grant);

endmodule

`default_nettype wire

//--- rename/rename.sv
`timescale 1ns/1ns
`default_nettype none
`include "ooo_defs.svh"

module rename (
	input  wire                        clock,
	input  wire                        arst_n,
	input  wire                        inst_valid,
	input  wire ooo_pkg::alu_func_e    inst_func,
	input  wire ooo_pkg::ar_idx_t      inst_dest,
	input  wire ooo_pkg::ar_idx_t      inst_src_a,
	input  wire ooo_pkg::ar_idx_t      inst_src_b,
	input  wire                        inst_use_imm,
	input  wire ooo_pkg::imm_t         inst_imm,
	output logic                       inst_ready,
	output ooo_pkg::pr_idx_t           src_a_tag,
	output ooo_pkg::pr_idx_t           src_b_tag,
	input  wire ooo_pkg::word_t        src_a_value,
	input  wire ooo_pkg::word_t        src_b_value,
	input  wire                        src_a_rdy,
	input  wire                        src_b_rdy,
	input  wire                        rob_full,
	output logic                       rob_alloc,
	output ooo_pkg::ar_idx_t           alloc_ar,
	output ooo_pkg::pr_idx_t           alloc_pr,
	output ooo_pkg::pr_idx_t           alloc_told,
	input  wire ooo_pkg::rob_idx_t     alloc_slot,
	input  wire                        retire_told_valid,
	input  wire ooo_pkg::pr_idx_t      retire_told,
	output logic                       clear_rdy,
	output ooo_pkg::pr_idx_t           clear_tag,
	output logic                       sim_issue,
	output logic                       mul_issue,
	output ooo_pkg::issue_t            issue_data,
	input  wire                        sim_busy
);

	ooo_pkg::pr_idx_t map_q [`NUM_AR];
	ooo_pkg::pr_idx_t fl_q [`FL_DEPTH];
	logic [`FL_W-1:0] fl_head_q;
	logic [`FL_W-1:0] fl_tail_q;
	logic [`FL_W:0]   fl_count_q;
	ooo_pkg::pr_idx_t new_tag;
	logic             is_mul;
	logic             accept;

	assign is_mul    = (inst_func == ooo_pkg::func_mul);
	assign src_a_tag = map_q[inst_src_a];
	assign src_b_tag = map_q[inst_src_b];
	assign new_tag   = fl_q[fl_head_q];    // Head of the free list

	// Operand b is not needed when the immediate replaces it
	assign inst_ready = !rob_full && src_a_rdy && (inst_use_imm || src_b_rdy) &&
		(is_mul || !sim_busy);
	assign accept = inst_valid && inst_ready;

	assign rob_alloc  = accept;
	assign alloc_ar   = inst_dest;
	assign alloc_pr   = new_tag;
	assign alloc_told = map_q[inst_dest];
	assign clear_rdy  = accept;
	assign clear_tag  = new_tag;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `NUM_AR; i++)
				map_q[i] <= ooo_pkg::pr_idx_t'(i);     // Identity mapping
		end else if (accept) begin
			map_q[inst_dest] <= new_tag;
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `FL_DEPTH; i++)
				fl_q[i] <= ooo_pkg::pr_idx_t'(`NUM_AR + i);
			fl_head_q  <= '0;
			fl_tail_q  <= '0;
			fl_count_q <= (`FL_W+1)'(`FL_DEPTH);
		end else begin
			if (retire_told_valid) begin
				fl_q[fl_tail_q] <= retire_told;
				fl_tail_q <= fl_tail_q + 1'b1;
			end
			if (accept)
				fl_head_q <= fl_head_q + 1'b1;
			fl_count_q <= fl_count_q + {{`FL_W{1'b0}}, retire_told_valid} -
				{{`FL_W{1'b0}}, accept};
		end
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			sim_issue <= 1'b0;
			mul_issue <= 1'b0;
		end else begin
			sim_issue <= accept && !is_mul;
			mul_issue <= accept && is_mul;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			issue_data.func <= inst_func;
			issue_data.a    <= src_a_value;
			issue_data.b    <= inst_use_imm ? ooo_pkg::word_t'(inst_imm) : src_b_value;
			issue_data.tag  <= new_tag;
			issue_data.slot <= alloc_slot;
		end
	end

	// ROB depth keeps enough registers free
	a_fl_not_empty: assert property (@(posedge clock) disable iff (!arst_n)
		accept |-> fl_count_q != '0)
		else $error("rename: pop from empty free list");

endmodule

`default_nettype wire

//--- src.f
+incdir+common
common/ooo_pkg.sv
common/cdb_if.sv
rename/rename.sv
exec/alu_sim.sv
exec/alu_mul.sv
verilog/cdb_arbiter.sv
verilog/prf.sv
verilog/rob.sv
verilog/pipeline.sv
test/pipeline_tb.sv

//--- test/pipeline_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "ooo_defs.svh"

module pipeline_tb;

	localparam int HALF_PERIOD = 10;
	localparam int WAIT_LIMIT  = 200;    // Cycles before a wait gives up
	localparam int RANDOM_ROWS = 80;

	typedef struct packed {
		ooo_pkg::alu_func_e func;
		ooo_pkg::ar_idx_t   dest;
		ooo_pkg::ar_idx_t   src_a;
		ooo_pkg::ar_idx_t   src_b;
		logic               use_imm;
		ooo_pkg::imm_t      imm;
	} row_t;

	logic               clock;
	logic               arst_n;
	logic               inst_valid;
	ooo_pkg::alu_func_e inst_func;
	ooo_pkg::ar_idx_t   inst_dest;
	ooo_pkg::ar_idx_t   inst_src_a;
	ooo_pkg::ar_idx_t   inst_src_b;
	logic               inst_use_imm;
	ooo_pkg::imm_t      inst_imm;
	logic               inst_ready;
	logic               commit_valid;
	ooo_pkg::ar_idx_t   commit_ar;
	ooo_pkg::word_t     commit_value;

	row_t               rows [$];
	ooo_pkg::word_t     arch_q [`NUM_AR];    // Reference register file
	ooo_pkg::ar_idx_t   exp_ar_q [$];
	ooo_pkg::word_t     exp_value_q [$];
	int                 stall_cycles;
	integer             seed;

	pipeline dut0 (
		.clock(clock),
		.arst_n(arst_n),
		.inst_valid(inst_valid),
		.inst_func(inst_func),
		.inst_dest(inst_dest),
		.inst_src_a(inst_src_a),
		.inst_src_b(inst_src_b),
		.inst_use_imm(inst_use_imm),
		.inst_imm(inst_imm),
		.inst_ready(inst_ready),
		.commit_valid(commit_valid),
		.commit_ar(commit_ar),
		.commit_value(commit_value)
	);

	initial begin
		clock = 1'b0;
		forever #HALF_PERIOD clock = ~clock;
	end

	task automatic abort_run(input string why);
		$display("Error at %0t ns: %s", $time, why);
		$display("Simulation failed");
		$fatal(1, "run aborted");
	endtask

	task automatic check_value(input logic [63:0] got, input logic [63:0] expected,
		input string what);
		if (got !== expected) begin
			$display("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, expected);
			$display("Simulation failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// In-order architectural result of one row
	function automatic ooo_pkg::word_t model_result(input row_t r);
		ooo_pkg::word_t a;
		ooo_pkg::word_t b;
		a = arch_q[r.src_a];
		b = r.use_imm ? ooo_pkg::word_t'(r.imm) : arch_q[r.src_b];
		case (r.func)
			ooo_pkg::func_add: return a + b;
			ooo_pkg::func_sub: return a - b;
			ooo_pkg::func_and: return a & b;
			ooo_pkg::func_xor: return a ^ b;
			ooo_pkg::func_mul: return a * b;    // Low 64 bits
			default:           return '0;
		endcase
	endfunction

	task automatic model_accept(input row_t r);
		ooo_pkg::word_t res;
		res = model_result(r);
		arch_q[r.dest] = res;
		exp_ar_q.push_back(r.dest);
		exp_value_q.push_back(res);
	endtask

	function automatic void add_row(input ooo_pkg::alu_func_e func, input int dest,
		input int src_a, input int src_b, input logic use_imm, input int imm);
		row_t r;
		r.func    = func;
		r.dest    = ooo_pkg::ar_idx_t'(dest);
		r.src_a   = ooo_pkg::ar_idx_t'(src_a);
		r.src_b   = ooo_pkg::ar_idx_t'(src_b);
		r.use_imm = use_imm;
		r.imm     = ooo_pkg::imm_t'(imm);
		rows.push_back(r);
	endfunction

	// Called on a falling edge, returns on the falling edge after acceptance
	task automatic apply_row(input row_t r);
		int waited;
		waited       = 0;
		inst_valid   = 1'b1;
		inst_func    = r.func;
		inst_dest    = r.dest;
		inst_src_a   = r.src_a;
		inst_src_b   = r.src_b;
		inst_use_imm = r.use_imm;
		inst_imm     = r.imm;
		#(HALF_PERIOD / 2);
		while (!inst_ready) begin
			stall_cycles++;
			waited++;
			if (waited > WAIT_LIMIT)
				abort_run("inst_ready stayed low for an offered instruction");
			else begin
				@(negedge clock);
				#(HALF_PERIOD / 2);
			end
		end
		@(posedge clock);
		model_accept(r);
		@(negedge clock);
	endtask

	task automatic run_table();
		for (int i = 0; i < rows.size(); i++)
			apply_row(rows[i]);
		inst_valid = 1'b0;
		rows.delete();
	endtask

	// Commits must match the model in program order
	always @(negedge clock) begin
		if (arst_n && commit_valid) begin
			if (exp_ar_q.size() == 0)
				abort_run("commit with no instruction outstanding");
			else begin
				check_value(64'(commit_ar), 64'(exp_ar_q.pop_front()), "commit_ar");
				check_value(commit_value, exp_value_q.pop_front(), "commit_value");
			end
		end
	end

	initial begin
		int          waited;
		logic [31:0] r;
		seed         = 32'hc879_6808;
		arst_n       = 1'b0;
		inst_valid   = 1'b0;
		inst_func    = ooo_pkg::func_add;
		inst_dest    = '0;
		inst_src_a   = '0;
		inst_src_b   = '0;
		inst_use_imm = 1'b0;
		inst_imm     = '0;
		stall_cycles = 0;
		for (int i = 0; i < `NUM_AR; i++)
			arch_q[i] = '0;
		repeat (4) @(negedge clock);
		arst_n = 1'b1;

		// Quiet after reset, then ready
		repeat (3) begin
			@(negedge clock);
			check_value(64'(commit_valid), 64'd0, "commit_valid after reset");
		end
		waited = 0;
		while (!inst_ready) begin
			waited++;
			if (waited > WAIT_LIMIT)
				abort_run("inst_ready did not rise after reset");
			else
				@(negedge clock);
		end

		add_row(ooo_pkg::func_add, 1, 0, 0, 1'b1, 25);
		add_row(ooo_pkg::func_add, 2, 0, 0, 1'b1, 7);
		add_row(ooo_pkg::func_add, 3, 1, 2, 1'b0, 0);
		add_row(ooo_pkg::func_sub, 4, 1, 2, 1'b0, 0);
		add_row(ooo_pkg::func_and, 5, 3, 4, 1'b0, 0);
		add_row(ooo_pkg::func_xor, 6, 3, 1, 1'b0, 0);
		add_row(ooo_pkg::func_sub, 7, 2, 1, 1'b0, 0);    // Wraps below zero
		run_table();

		// Adds overtake the multiply, r12 waits for the product
		add_row(ooo_pkg::func_mul, 8, 1, 2, 1'b0, 0);
		add_row(ooo_pkg::func_add, 9, 3, 0, 1'b1, 1);
		add_row(ooo_pkg::func_add, 10, 4, 0, 1'b1, 2);
		add_row(ooo_pkg::func_xor, 11, 5, 6, 1'b0, 0);
		add_row(ooo_pkg::func_add, 12, 8, 1, 1'b0, 0);
		run_table();

		// Multiplies win the CDB while the add waits in alu_sim
		add_row(ooo_pkg::func_mul, 13, 1, 2, 1'b0, 0);
		add_row(ooo_pkg::func_mul, 14, 2, 2, 1'b0, 0);
		add_row(ooo_pkg::func_mul, 15, 1, 1, 1'b0, 0);
		add_row(ooo_pkg::func_mul, 16, 3, 2, 1'b0, 0);
		add_row(ooo_pkg::func_add, 17, 4, 0, 1'b1, 3);
		run_table();
		stall_cycles = 0;
		// Each multiply waits for the product before it
		for (int i = 0; i < `ROB_DEPTH + 4; i++)
			add_row(ooo_pkg::func_mul, 18 + i % 12, (i == 0) ? 3 : 18 + (i - 1) % 12,
				1 + i % 4, 1'b0, 0);
		run_table();
		check_value(64'(stall_cycles != 0), 64'd1, "inst_ready drop in a dependent chain");

		for (int i = 0; i < RANDOM_ROWS; i++) begin
			r = $random(seed);
			add_row((r[2:0] > 3'd4) ? ooo_pkg::func_mul : ooo_pkg::alu_func_e'(r[2:0]),
				int'(r[7:3]), int'(r[12:8]), int'(r[17:13]), r[18], int'(r[26:19]));
		end
		run_table();

		waited = 0;
		while (exp_ar_q.size() != 0) begin
			waited++;
			if (waited > WAIT_LIMIT)
				abort_run("outstanding instructions did not commit");
			else
				@(negedge clock);
		end
		repeat (10) @(negedge clock);    // Room for a stray commit
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/cdb_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module cdb_arbiter (
	cdb_if.arbiter sim,
	cdb_if.arbiter mul,
	cdb_if.unit    bcast
);

	// Multiplier first, alu_sim can wait in its hold state
	assign mul.grant = mul.req;
	assign sim.grant = sim.req && !mul.req;

	assign bcast.valid    = mul.valid || sim.valid;
	assign bcast.tag      = mul.grant ? mul.tag : sim.tag;
	assign bcast.value    = mul.grant ? mul.value : sim.value;
	assign bcast.rob_slot = mul.grant ? mul.rob_slot : sim.rob_slot;

	always_comb begin
		a_one_result: assert (!(mul.valid && sim.valid))
			else $error("cdb_arbiter: two results taken in one cycle");
	end

endmodule

`default_nettype wire

//--- verilog/pipeline.sv
`timescale 1ns/1ns
`default_nettype none

module pipeline (
	input  wire                      clock,
	input  wire                      arst_n,
	input  wire                      inst_valid,
	input  wire ooo_pkg::alu_func_e  inst_func,
	input  wire ooo_pkg::ar_idx_t    inst_dest,
	input  wire ooo_pkg::ar_idx_t    inst_src_a,
	input  wire ooo_pkg::ar_idx_t    inst_src_b,
	input  wire                      inst_use_imm,
	input  wire ooo_pkg::imm_t       inst_imm,
	output wire                      inst_ready,
	output wire                      commit_valid,
	output wire ooo_pkg::ar_idx_t    commit_ar,
	output wire ooo_pkg::word_t      commit_value
);

	ooo_pkg::pr_idx_t  src_a_tag;
	ooo_pkg::pr_idx_t  src_b_tag;
	ooo_pkg::word_t    src_a_value;
	ooo_pkg::word_t    src_b_value;
	logic              src_a_rdy;
	logic              src_b_rdy;
	logic              rob_full;
	logic              rob_alloc;
	ooo_pkg::ar_idx_t  alloc_ar;
	ooo_pkg::pr_idx_t  alloc_pr;
	ooo_pkg::pr_idx_t  alloc_told;
	ooo_pkg::rob_idx_t alloc_slot;
	logic              retire_told_valid;
	ooo_pkg::pr_idx_t  retire_told;
	logic              clear_rdy;
	ooo_pkg::pr_idx_t  clear_tag;
	logic              sim_issue;
	logic              mul_issue;
	ooo_pkg::issue_t   issue_data;
	logic              sim_busy;

	cdb_if sim_bus ();
	cdb_if mul_bus ();
	cdb_if cdb_bus ();    // The one shared broadcast

	rename rename0 (
		.clock(clock),
		.arst_n(arst_n),
		.inst_valid(inst_valid),
		.inst_func(inst_func),
		.inst_dest(inst_dest),
		.inst_src_a(inst_src_a),
		.inst_src_b(inst_src_b),
		.inst_use_imm(inst_use_imm),
		.inst_imm(inst_imm),
		.inst_ready(inst_ready),
		.src_a_tag(src_a_tag),
		.src_b_tag(src_b_tag),
		.src_a_value(src_a_value),
		.src_b_value(src_b_value),
		.src_a_rdy(src_a_rdy),
		.src_b_rdy(src_b_rdy),
		.rob_full(rob_full),
		.rob_alloc(rob_alloc),
		.alloc_ar(alloc_ar),
		.alloc_pr(alloc_pr),
		.alloc_told(alloc_told),
		.alloc_slot(alloc_slot),
		.retire_told_valid(retire_told_valid),
		.retire_told(retire_told),
		.clear_rdy(clear_rdy),
		.clear_tag(clear_tag),
		.sim_issue(sim_issue),
		.mul_issue(mul_issue),
		.issue_data(issue_data),
		.sim_busy(sim_busy)
	);

	prf prf0 (
		.clock(clock),
		.arst_n(arst_n),
		.src_a_tag(src_a_tag),
		.src_b_tag(src_b_tag),
		.src_a_value(src_a_value),
		.src_b_value(src_b_value),
		.src_a_rdy(src_a_rdy),
		.src_b_rdy(src_b_rdy),
		.clear_rdy(clear_rdy),
		.clear_tag(clear_tag),
		.cdb(cdb_bus)
	);

	alu_sim alu_sim0 (
		.clock(clock),
		.arst_n(arst_n),
		.issue(sim_issue),
		.issue_data(issue_data),
		.busy(sim_busy),
		.bus(sim_bus)
	);

	alu_mul alu_mul0 (
		.clock(clock),
		.arst_n(arst_n),
		.issue(mul_issue),
		.issue_data(issue_data),
		.bus(mul_bus)
	);

	cdb_arbiter cdb_arbiter0 (
		.sim(sim_bus),
		.mul(mul_bus),
		.bcast(cdb_bus)
	);

	rob rob0 (
		.clock(clock),
		.arst_n(arst_n),
		.rob_alloc(rob_alloc),
		.alloc_ar(alloc_ar),
		.alloc_pr(alloc_pr),
		.alloc_told(alloc_told),
		.alloc_slot(alloc_slot),
		.rob_full(rob_full),
		.cdb(cdb_bus),
		.retire_told_valid(retire_told_valid),
		.retire_told(retire_told),
		.commit_valid(commit_valid),
		.commit_ar(commit_ar),
		.commit_value(commit_value)
	);

endmodule

`default_nettype wire

//--- verilog/prf.sv
`timescale 1ns/1ns
`default_nettype none
`include "ooo_defs.svh"

module prf (
	input  wire                     clock,
	input  wire                     arst_n,
	input  wire ooo_pkg::pr_idx_t   src_a_tag,
	input  wire ooo_pkg::pr_idx_t   src_b_tag,
	output ooo_pkg::word_t          src_a_value,
	output ooo_pkg::word_t          src_b_value,
	output logic                    src_a_rdy,
	output logic                    src_b_rdy,
	input  wire                     clear_rdy,
	input  wire ooo_pkg::pr_idx_t   clear_tag,
	cdb_if.listener                 cdb
);

	ooo_pkg::word_t     value_q [`NUM_PR];
	logic [`NUM_PR-1:0] rdy_q;

	// Architectural state starts at zero
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			rdy_q <= '1;    // Free ones too, rename clears on allocation
			for (int i = 0; i < `NUM_PR; i++)
				value_q[i] <= '0;
		end else begin
			if (cdb.valid) begin
				value_q[cdb.tag] <= cdb.value;
				rdy_q[cdb.tag]   <= 1'b1;
			end
			if (clear_rdy)
				rdy_q[clear_tag] <= 1'b0;
		end
	end

	assign src_a_value = value_q[src_a_tag];
	assign src_b_value = value_q[src_b_tag];
	assign src_a_rdy   = rdy_q[src_a_tag];
	assign src_b_rdy   = rdy_q[src_b_tag];

	// A register being allocated cannot have a result in flight
	a_no_clear_clash: assert property (@(posedge clock) disable iff (!arst_n)
		!(clear_rdy && cdb.valid && clear_tag == cdb.tag))
		else $error("prf: clear and broadcast on the same tag");

endmodule

`default_nettype wire

//--- verilog/rob.sv
`timescale 1ns/1ns
`default_nettype none
`include "ooo_defs.svh"

module rob (
	input  wire                     clock,
	input  wire                     arst_n,
	input  wire                     rob_alloc,
	input  wire ooo_pkg::ar_idx_t   alloc_ar,
	input  wire ooo_pkg::pr_idx_t   alloc_pr,
	input  wire ooo_pkg::pr_idx_t   alloc_told,
	output ooo_pkg::rob_idx_t       alloc_slot,
	output logic                    rob_full,
	cdb_if.listener                 cdb,
	output logic                    retire_told_valid,
	output ooo_pkg::pr_idx_t        retire_told,
	output logic                    commit_valid,
	output ooo_pkg::ar_idx_t        commit_ar,
	output ooo_pkg::word_t          commit_value
);

	ooo_pkg::ar_idx_t      ar_q [`ROB_DEPTH];
	ooo_pkg::pr_idx_t      pr_q [`ROB_DEPTH];
	ooo_pkg::pr_idx_t      told_q [`ROB_DEPTH];
	ooo_pkg::word_t        value_q [`ROB_DEPTH];
	logic [`ROB_DEPTH-1:0] done_q;
	ooo_pkg::rob_idx_t     head_q;
	ooo_pkg::rob_idx_t     tail_q;
	logic [`ROB_W:0]       count_q;
	logic                  retire;

	assign retire     = (count_q != '0) && done_q[head_q];
	assign rob_full   = count_q[`ROB_W];     // Set only at count == depth
	assign alloc_slot = tail_q;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			head_q            <= '0;
			tail_q            <= '0;
			count_q           <= '0;
			done_q            <= '0;
			commit_valid      <= 1'b0;
			retire_told_valid <= 1'b0;
		end else begin
			if (rob_alloc) begin
				done_q[tail_q] <= 1'b0;
				tail_q <= tail_q + 1'b1;
			end
			if (cdb.valid)
				done_q[cdb.rob_slot] <= 1'b1;
			if (retire) begin
				done_q[head_q] <= 1'b0;
				head_q <= head_q + 1'b1;
			end
			count_q <= count_q + {{`ROB_W{1'b0}}, rob_alloc} - {{`ROB_W{1'b0}}, retire};
			commit_valid      <= retire;
			retire_told_valid <= retire;
		end
	end

	always_ff @(posedge clock) begin
		if (rob_alloc) begin
			ar_q[tail_q]   <= alloc_ar;
			pr_q[tail_q]   <= alloc_pr;
			told_q[tail_q] <= alloc_told;
		end
		if (cdb.valid)
			value_q[cdb.rob_slot] <= cdb.value;
		if (retire) begin
			commit_ar    <= ar_q[head_q];
			commit_value <= value_q[head_q];
			retire_told  <= told_q[head_q];
		end
	end

	// Broadcast completes its own entry, and only once
	a_bcast_match: assert property (@(posedge clock) disable iff (!arst_n)
		cdb.valid |-> !done_q[cdb.rob_slot] && pr_q[cdb.rob_slot] == cdb.tag)
		else $error("rob: broadcast does not match its entry");

	a_no_overflow: assert property (@(posedge clock) disable iff (!arst_n)
		rob_alloc |-> !rob_full)
		else $error("rob: allocation into a full buffer");

endmodule

`default_nettype wire
